//--- logic/lut_settings.svh
`ifndef LUT_SETTINGS_SVH
`define LUT_SETTINGS_SVH

// Width of one table entry as seen by the datapath
`define LUT_DATA_W 32

// Bus beat width, also the width of one table word
`define LUT_BUS_W 64

// Table word address, top bit picks the ping-pong half
`define LUT_ADDR_W 10

// External byte address
`define LUT_BUS_ADDR_W 32

// Burst length field, beats minus one
`define LUT_LEN_W 8

// Address generator counters
`define LUT_CNT_W 10

`endif

//--- logic/lut_bus_pkg.sv
`include "lut_settings.svh"

// Types of the external read bus
package lut_bus_pkg;

   // Byte address driven toward the bus
   typedef logic [`LUT_BUS_ADDR_W-1:0] bus_addr_t;

   // One read beat, same width as a table word
   typedef logic [`LUT_BUS_W-1:0] bus_word_t;

   // Beats minus one
   typedef logic [`LUT_LEN_W-1:0] burst_len_t;

   // Beat count of a burst, one bit wider than the length field
   localparam int BUS_BEAT_CNT_W = `LUT_LEN_W + 1;

   // Bytes in one beat
   localparam int BUS_WORD_BYTES = `LUT_BUS_W / 8;

endpackage

//--- logic/lut_cfg_pkg.sv
`include "lut_settings.svh"

// Types of table addressing and generator configuration
package lut_cfg_pkg;

   // Entries per table word
   localparam int LUT_LANES = `LUT_BUS_W / `LUT_DATA_W;

   // Lane select width, never zero
   localparam int LUT_LANE_W = (LUT_LANES > 1) ? $clog2(LUT_LANES) : 1;

   // Word address width inside one ping-pong half
   localparam int LUT_HALF_W = `LUT_ADDR_W - 1;

   // Table word address including the half bit
   typedef logic [`LUT_ADDR_W-1:0] tab_addr_t;

   typedef logic [`LUT_DATA_W-1:0] entry_t;

   typedef logic [LUT_LANE_W-1:0] lane_sel_t;

   // Period, duty, shift, incr and iteration counts
   typedef logic [`LUT_CNT_W-1:0] gen_cnt_t;

   // Word within one half in the upper bits, lane in the low bits
   typedef logic [LUT_HALF_W+LUT_LANE_W-1:0] lut_index_t;

endpackage

//--- logic/lut_load_ctrl.sv
`timescale 1ns/1ps

module lut_load_ctrl
   import lut_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   input  logic       disabled_i,
   input  bus_addr_t  bus_addr_cfg_i,
   input  burst_len_t len_cfg_i,
   input  logic       ping_pong_i,
   input  logic       bus_rvalid_i,
   input  logic       bus_rready_i,
   input  logic       bus_rlast_i,
   output logic       done_o,
   output logic       bus_req_o,
   output bus_addr_t  bus_addr_o,
   output burst_len_t bus_len_o,
   output logic       load_active_o,
   output logic       gen_start_o,
   output logic       ping_state_o
);

   logic start; // Enabled run
   logic last_beat;
   logic done_q;
   logic req_q;
   logic active_q;
   logic ping_q;

   assign start     = run_i && !disabled_i;
   assign last_beat = bus_rvalid_i && bus_rready_i && bus_rlast_i;

   // Generator starts on the same edge as the request
   assign gen_start_o = start;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q   <= 1'b1; // Idle unit reports done
         req_q    <= 1'b0;
         active_q <= 1'b0;
      end else if (start) begin
         done_q   <= 1'b0;
         req_q    <= 1'b1;
         active_q <= 1'b1;
      end else if (last_beat) begin
         done_q   <= 1'b1;
         req_q    <= 1'b0;
         active_q <= 1'b0; // Leftover generator addresses get dropped
      end
   end

   // Burst parameters held for the whole load
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr_o <= '0;
         bus_len_o  <= '0;
      end else if (start) begin
         bus_addr_o <= bus_addr_cfg_i;
         bus_len_o  <= len_cfg_i;
      end
   end

   // Even a disabled run moves the ping-pong state
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ping_q <= 1'b0;
      end else if (run_i) begin
         ping_q <= ping_pong_i ? !ping_q : 1'b0;
      end
   end

   assign done_o        = done_q;
   assign bus_req_o     = req_q;
   assign load_active_o = active_q;
   assign ping_state_o  = ping_q;

   // No new load while a request is still out
   a_run_when_idle : assert property (@(posedge clk) disable iff (rst)
      start |-> !bus_req_o);

   // The join keeps ready low outside a load
   a_beat_in_load : assert property (@(posedge clk) disable iff (rst)
      (bus_rvalid_i && bus_rready_i) |-> load_active_o);

endmodule

//--- logic/lut_addr_gen.sv
`timescale 1ns/1ps

module lut_addr_gen
   import lut_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      start_i,
   input  gen_cnt_t  iterations_i,
   input  gen_cnt_t  period_i,
   input  gen_cnt_t  duty_i,
   input  gen_cnt_t  shift_i,
   input  gen_cnt_t  incr_i,
   input  logic      gen_ready_i,
   output logic      gen_valid_o,
   output tab_addr_t gen_addr_o,
   output logic      gen_done_o
);

   logic      running_q;
   logic      done_q;
   tab_addr_t addr_q;
   gen_cnt_t  per_cnt_q;
   gen_cnt_t  iter_cnt_q;
   logic      in_duty;
   logic      step;
   logic      end_period;
   logic      end_iter;
   tab_addr_t addr_incr;

   assign in_duty = per_cnt_q < duty_i; // Active part of the period

   // Skipped steps advance on their own, active ones wait for ready
   assign step = running_q && (!in_duty || gen_ready_i);

   assign end_period = (per_cnt_q + 1'b1) >= period_i;
   assign end_iter   = (iter_cnt_q + 1'b1) >= iterations_i;

   assign addr_incr = in_duty ? addr_q + tab_addr_t'(incr_i) : addr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running_q  <= 1'b0;
         done_q     <= 1'b0;
         addr_q     <= '0;
         per_cnt_q  <= '0;
         iter_cnt_q <= '0;
      end else if (start_i) begin
         running_q  <= 1'b1;
         done_q     <= 1'b0;
         addr_q     <= '0;
         per_cnt_q  <= '0;
         iter_cnt_q <= '0;
      end else if (step) begin
         if (end_period) begin
            per_cnt_q <= '0;
            addr_q    <= addr_incr + tab_addr_t'(shift_i);
            if (end_iter) begin
               running_q <= 1'b0;
               done_q    <= 1'b1;
            end else begin
               iter_cnt_q <= iter_cnt_q + 1'b1;
            end
         end else begin
            per_cnt_q <= per_cnt_q + 1'b1;
            addr_q    <= addr_incr;
         end
      end
   end

   assign gen_valid_o = running_q && in_duty;
   assign gen_addr_o  = addr_q;
   assign gen_done_o  = done_q;

   // Duty longer than the period would never skip
   a_duty_in_period : assert property (@(posedge clk) disable iff (rst)
      running_q |-> (duty_i <= period_i));

endmodule

//--- logic/lut_join.sv
`timescale 1ns/1ps

module lut_join #(
   parameter type first_t  = logic,
   parameter type second_t = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    clear_i,
   input  logic    first_valid_i,
   output logic    first_ready_o,
   input  first_t  first_data_i,
   input  logic    second_valid_i,
   output logic    second_ready_o,
   input  second_t second_data_i,
   output logic    result_valid_o,
   output first_t  result_first_o,
   output second_t result_second_o
);

   logic    fire;
   logic    valid_q;
   first_t  first_q;
   second_t second_q;

   // Each side is taken only together with the other
   assign first_ready_o  = second_valid_i && !clear_i;
   assign second_ready_o = first_valid_i && !clear_i;
   assign fire           = first_valid_i && second_valid_i && !clear_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= fire; // Also empties the pair on clear
      end
   end

   // Payload pair, no reset
   always_ff @(posedge clk) begin
      if (fire) begin
         first_q  <= first_data_i;
         second_q <= second_data_i;
      end
   end

   assign result_valid_o  = valid_q;
   assign result_first_o  = first_q;
   assign result_second_o = second_q;

endmodule

//--- logic/lut_dual_ram.sv
`timescale 1ns/1ps

`include "lut_settings.svh"

module lut_dual_ram
   import lut_bus_pkg::*;
   import lut_cfg_pkg::*;
(
   input  logic      clk,
   input  tab_addr_t rd_addr_i,
   output bus_word_t rd_data_o,
   input  logic      wr_en_i,
   input  tab_addr_t wr_addr_i,
   input  bus_word_t wr_data_i
);

   localparam int DEPTH = 2 ** `LUT_ADDR_W;

   bus_word_t mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Read port, old data on a same-address write
   always_ff @(posedge clk) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

//--- logic/lut_lane_read.sv
`timescale 1ns/1ps

`include "lut_settings.svh"

module lut_lane_read
   import lut_bus_pkg::*;
   import lut_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  lut_index_t index_i,
   input  logic       read_half_i,
   output tab_addr_t  rd_addr_o,
   input  bus_word_t  rd_data_i,
   output entry_t     entry_o
);

   logic [LUT_HALF_W-1:0] word_idx;
   lane_sel_t             lane_idx;
   tab_addr_t             rd_addr_q;
   lane_sel_t             lane_q0; // Aligned with rd_addr_q
   lane_sel_t             lane_q1; // Aligned with rd_data_i

   assign word_idx = index_i[LUT_HALF_W+LUT_LANE_W-1:LUT_LANE_W];
   assign lane_idx = index_i[LUT_LANE_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr_q <= '0;
         lane_q0   <= '0;
         lane_q1   <= '0;
      end else begin
         rd_addr_q <= {read_half_i, word_idx};
         lane_q0   <= lane_idx;
         lane_q1   <= lane_q0;
      end
   end

   assign rd_addr_o = rd_addr_q;

   // Lane 0 sits in the low bits of the word
   assign entry_o = rd_data_i[lane_q1*`LUT_DATA_W +: `LUT_DATA_W];

endmodule

//--- logic/lut_read_top.sv
`timescale 1ns/1ps

`include "lut_settings.svh"

module lut_read_top
   import lut_bus_pkg::*;
   import lut_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   input  logic       disabled_i,
   input  logic       ping_pong_i,
   input  bus_addr_t  bus_addr_cfg_i,
   input  burst_len_t len_cfg_i,
   input  gen_cnt_t   iterations_i,
   input  gen_cnt_t   period_i,
   input  gen_cnt_t   duty_i,
   input  gen_cnt_t   shift_i,
   input  gen_cnt_t   incr_i,
   output logic       done_o,
   output logic       bus_req_o,
   output bus_addr_t  bus_addr_o,
   output burst_len_t bus_len_o,
   input  logic       bus_rvalid_i,
   input  bus_word_t  bus_rdata_i,
   input  logic       bus_rlast_i,
   output logic       bus_rready_o,
   input  lut_index_t index_i,
   output entry_t     entry_o
);

   logic      ping_state;
   logic      load_active;
   logic      gen_start;
   logic      gen_valid;
   logic      gen_ready;
   tab_addr_t gen_addr;
   logic      wr_en;
   tab_addr_t wr_addr;
   bus_word_t wr_data;
   logic      wr_half;
   tab_addr_t wr_ram_addr;
   logic      rd_half;
   tab_addr_t rd_addr;
   bus_word_t rd_data;

   // Loads fill one half while lookups read the other
   assign wr_half     = ping_state ^ wr_addr[`LUT_ADDR_W-1];
   assign wr_ram_addr = {wr_half, wr_addr[`LUT_ADDR_W-2:0]};
   assign rd_half     = ping_pong_i && !ping_state;

   lut_load_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .disabled_i     (disabled_i),
      .bus_addr_cfg_i (bus_addr_cfg_i),
      .len_cfg_i      (len_cfg_i),
      .ping_pong_i    (ping_pong_i),
      .bus_rvalid_i   (bus_rvalid_i),
      .bus_rready_i   (bus_rready_o),
      .bus_rlast_i    (bus_rlast_i),
      .done_o         (done_o),
      .bus_req_o      (bus_req_o),
      .bus_addr_o     (bus_addr_o),
      .bus_len_o      (bus_len_o),
      .load_active_o  (load_active),
      .gen_start_o    (gen_start),
      .ping_state_o   (ping_state)
   );

   lut_addr_gen u_gen (
      .clk          (clk),
      .rst          (rst),
      .start_i      (gen_start),
      .iterations_i (iterations_i),
      .period_i     (period_i),
      .duty_i       (duty_i),
      .shift_i      (shift_i),
      .incr_i       (incr_i),
      .gen_ready_i  (gen_ready),
      .gen_valid_o  (gen_valid),
      .gen_addr_o   (gen_addr),
      .gen_done_o   ()          // Load end is marked by rlast
   );

   lut_join #(
      .first_t  (tab_addr_t),
      .second_t (bus_word_t)
   ) u_join (
      .clk             (clk),
      .rst             (rst),
      .clear_i         (!load_active),
      .first_valid_i   (gen_valid),
      .first_ready_o   (gen_ready),
      .first_data_i    (gen_addr),
      .second_valid_i  (bus_rvalid_i),
      .second_ready_o  (bus_rready_o),
      .second_data_i   (bus_rdata_i),
      .result_valid_o  (wr_en),
      .result_first_o  (wr_addr),
      .result_second_o (wr_data)
   );

   lut_dual_ram u_ram (
      .clk       (clk),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_ram_addr),
      .wr_data_i (wr_data)
   );

   lut_lane_read u_lane (
      .clk         (clk),
      .rst         (rst),
      .index_i     (index_i),
      .read_half_i (rd_half),
      .rd_addr_o   (rd_addr),
      .rd_data_i   (rd_data),
      .entry_o     (entry_o)
   );

endmodule

//--- test/lut_tb.sv
`timescale 1ns/1ps

`include "lut_settings.svh"

module lut_tb
   import lut_bus_pkg::*;
   import lut_cfg_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int IDX_W      = $bits(lut_index_t);
   localparam int LEN_LIN    = 63;
   localparam int LEN_STR    = 29;
   localparam int LEN_PA     = 47;
   localparam int LEN_PB     = 31;
   localparam int LEN_PC     = 15;
   localparam int SUM_BEATS  = 2 * (LEN_LIN + 1) + (LEN_STR + 1) + (LEN_PA + 1)
                               + (LEN_PB + 1) + (LEN_PC + 1);
   localparam int SWEEPS     = 6;
   localparam int WATCHDOG_CYCLES = SUM_BEATS * 20 + SWEEPS * (2 ** IDX_W + 8) + 200;

   logic       clk;
   logic       rst;
   logic       run;
   logic       disabled;
   logic       ping_pong;
   bus_addr_t  bus_addr_cfg;
   burst_len_t len_cfg;
   gen_cnt_t   iterations;
   gen_cnt_t   period;
   gen_cnt_t   duty;
   gen_cnt_t   shift;
   gen_cnt_t   incr;
   logic       done;
   logic       bus_req;
   bus_addr_t  bus_addr;
   burst_len_t bus_len;
   logic       bus_rready;
   lut_index_t index;
   entry_t     entry;

   // Bus model state
   logic       bus_rvalid = 1'b0;
   bus_word_t  bus_rdata  = '0;
   logic       bus_rlast  = 1'b0;
   int         beat_cnt   = 0;
   logic       gaps_on;

   // Reference table and lookup checker state
   bus_word_t  ref_mem [2 ** `LUT_ADDR_W];
   bit         ref_known [2 ** `LUT_ADDR_W];
   logic       model_ping;
   logic       look_valid;
   entry_t     look_exp;
   logic       pipe_valid [2];
   entry_t     pipe_exp [2];
   lut_index_t pipe_idx [2];
   logic       done_prev = 1'b1;
   logic       last_prev = 1'b0;
   string      test_name;

   lut_read_top dut (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run),
      .disabled_i     (disabled),
      .ping_pong_i    (ping_pong),
      .bus_addr_cfg_i (bus_addr_cfg),
      .len_cfg_i      (len_cfg),
      .iterations_i   (iterations),
      .period_i       (period),
      .duty_i         (duty),
      .shift_i        (shift),
      .incr_i         (incr),
      .done_o         (done),
      .bus_req_o      (bus_req),
      .bus_addr_o     (bus_addr),
      .bus_len_o      (bus_len),
      .bus_rvalid_i   (bus_rvalid),
      .bus_rdata_i    (bus_rdata),
      .bus_rlast_i    (bus_rlast),
      .bus_rready_o   (bus_rready),
      .index_i        (index),
      .entry_o        (entry)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
      $display("Errors found");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_failure(input string msg);
      $display("In test %s: %s", test_name, msg);
      $display("Errors found");
      $fatal(1, "protocol check failed");
   endtask

   task automatic check_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (exp === act) else report_mismatch(what, exp, act);
   endtask

   // Beat k of a burst at address a, both lanes depend on both
   function automatic bus_word_t beat_pattern(input bus_addr_t a, input int k);
      bus_addr_t kk;
      kk = bus_addr_t'(k);
      return {a + (kk << 4), ~a ^ (kk * 32'h0001_0101)};
   endfunction

   function automatic tab_addr_t ref_loc(input lut_index_t idx, input logic half);
      return {half, idx[LUT_HALF_W+LUT_LANE_W-1:LUT_LANE_W]};
   endfunction

   // Expected entry, lane 0 in the low bits of the word
   function automatic entry_t ref_entry(input lut_index_t idx, input logic half);
      bus_word_t w;
      int        lane;
      w    = ref_mem[ref_loc(idx, half)];
      lane = int'(idx[LUT_LANE_W-1:0]);
      return w[lane*`LUT_DATA_W +: `LUT_DATA_W];
   endfunction

   // Nested-loop address rule, k-th address takes beat k, extra addresses dropped
   task automatic model_load(input bus_addr_t base, input burst_len_t len,
                             input gen_cnt_t iters, input gen_cnt_t per,
                             input gen_cnt_t act, input gen_cnt_t shf, input gen_cnt_t inc);
      tab_addr_t a;
      tab_addr_t loc;
      int        beat;
      a    = '0;
      beat = 0;
      for (int it = 0; it < int'(iters); it++) begin
         for (int s = 0; s < int'(per); s++) begin
            if (s < int'(act)) begin
               if (beat <= int'(len)) begin
                  loc            = {model_ping ^ a[`LUT_ADDR_W-1], a[`LUT_ADDR_W-2:0]};
                  ref_mem[loc]   = beat_pattern(base, beat);
                  ref_known[loc] = 1'b1;
               end
               beat++;
               a = a + tab_addr_t'(inc);
            end
         end
         a = a + tab_addr_t'(shf);
      end
   endtask

   task automatic start_load(input bus_addr_t addr, input burst_len_t len,
                             input gen_cnt_t iters, input gen_cnt_t per, input gen_cnt_t act,
                             input gen_cnt_t shf, input gen_cnt_t inc,
                             input logic pp, input logic dis);
      @(posedge clk);
      bus_addr_cfg <= addr;
      len_cfg      <= len;
      iterations   <= iters;
      period       <= per;
      duty         <= act;
      shift        <= shf;
      incr         <= inc;
      ping_pong    <= pp;
      disabled     <= dis;
      run          <= 1'b1;
      @(posedge clk);
      run        <= 1'b0;
      model_ping = pp ? !model_ping : 1'b0; // Every run moves the ping state
      if (!dis) begin
         model_load(addr, len, iters, per, act, shf, inc);
      end
      @(posedge clk);
      check_value("done_o after run", 64'(dis), 64'(done));
      check_value("bus_req_o after run", 64'(!dis), 64'(bus_req));
      if (!dis) begin
         check_value("bus_addr_o", 64'(addr), 64'(bus_addr));
         check_value("bus_len_o", 64'(len), 64'(bus_len));
         while (!done) @(posedge clk);
         repeat (2) @(posedge clk); // Last write lands after done
      end
   endtask

   // One index per cycle over the whole index range
   task automatic lookup_sweep(input string name);
      logic      half;
      tab_addr_t loc;
      test_name = name;
      half      = ping_pong && !model_ping;
      for (int i = 0; i < 2 ** IDX_W; i++) begin
         loc = ref_loc(lut_index_t'(i), half);
         @(posedge clk);
         index      <= lut_index_t'(i);
         look_valid <= ref_known[loc]; // Never written words are skipped
         look_exp   <= ref_entry(lut_index_t'(i), half);
      end
      @(posedge clk);
      look_valid <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   // Bus model, answers each request with len+1 beats
   always @(posedge clk or posedge rst) begin
      int k;
      if (rst) begin
         bus_rvalid <= 1'b0;
         bus_rlast  <= 1'b0;
         beat_cnt   <= 0;
      end else if (!bus_req) begin
         bus_rvalid <= 1'b0;
         bus_rlast  <= 1'b0;
         beat_cnt   <= 0;
      end else begin
         k = beat_cnt;
         if (bus_rvalid && bus_rready) begin
            k = k + 1;
         end
         beat_cnt <= k;
         if (k > int'(bus_len)) begin
            bus_rvalid <= 1'b0; // Burst complete
            bus_rlast  <= 1'b0;
         end else if (!bus_rvalid || bus_rready) begin
            bus_rvalid <= !gaps_on || ($urandom_range(2, 0) != 0);
            bus_rdata  <= beat_pattern(bus_addr, k);
            bus_rlast  <= (k == int'(bus_len));
         end
      end
   end

   // Lookup compare, entry is due two edges after the index is sampled
   always @(posedge clk) begin
      if (rst) begin
         pipe_valid[0] <= 1'b0;
         pipe_valid[1] <= 1'b0;
      end else begin
         if (pipe_valid[1]) begin
            assert (entry === pipe_exp[1])
            else report_mismatch($sformatf("entry for index %0d", pipe_idx[1]),
                                 64'(pipe_exp[1]), 64'(entry));
         end
         pipe_valid[1] <= pipe_valid[0];
         pipe_exp[1]   <= pipe_exp[0];
         pipe_idx[1]   <= pipe_idx[0];
         pipe_valid[0] <= look_valid;
         pipe_exp[0]   <= look_exp;
         pipe_idx[0]   <= index;
      end
   end

   // done_o must rise exactly on the edge after the accepted rlast beat
   always @(posedge clk) begin
      if (!rst) begin
         if (done && !done_prev) begin
            assert (last_prev) else report_failure("done_o rose with no rlast beat before it");
         end
         if (last_prev) begin
            assert (done) else report_failure("done_o stayed low after the rlast beat");
         end
      end
      done_prev <= done;
      last_prev <= bus_rvalid && bus_rready && bus_rlast;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, a load or lookup never finished", WATCHDOG_CYCLES);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h9054));
      rst          = 1'b1;
      run          = 1'b0;
      disabled     = 1'b0;
      ping_pong    = 1'b0;
      bus_addr_cfg = '0;
      len_cfg      = '0;
      iterations   = '0;
      period       = '0;
      duty         = '0;
      shift        = '0;
      incr         = '0;
      index        = '0;
      gaps_on      = 1'b0;
      look_valid   = 1'b0;
      look_exp     = '0;
      model_ping   = 1'b0;
      test_name    = "reset";
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_value("done_o", 64'd1, 64'(done));
      check_value("bus_req_o", 64'd0, 64'(bus_req));
      check_value("bus_rready_o", 64'd0, 64'(bus_rready));

      test_name = "disabled run";
      start_load(32'h0000_8000, 8'd3, 10'd4, 10'd1, 10'd1, 10'd0, 10'd1, 1'b0, 1'b1);
      repeat (4) begin
         @(posedge clk);
         check_value("done_o held", 64'd1, 64'(done));
         check_value("bus_req_o held", 64'd0, 64'(bus_req));
         check_value("bus_rready_o held", 64'd0, 64'(bus_rready));
      end

      // More addresses than beats, the extra ones are dropped
      test_name = "linear load";
      start_load(32'h1000_0000, burst_len_t'(LEN_LIN), 10'd10, 10'd8, 10'd8, 10'd0, 10'd1,
                 1'b0, 1'b0);
      lookup_sweep("linear lookup");

      test_name = "linear load with gaps";
      gaps_on <= 1'b1;
      start_load(32'h2000_0400, burst_len_t'(LEN_LIN), 10'd10, 10'd8, 10'd8, 10'd0, 10'd1,
                 1'b0, 1'b0);
      lookup_sweep("gapped lookup");

      test_name = "strided load";
      start_load(32'h0BAD_0040, burst_len_t'(LEN_STR), 10'd20, 10'd4, 10'd2, 10'd5, 10'd3,
                 1'b0, 1'b0);
      lookup_sweep("strided lookup");

      // Lookups lag one load behind with ping-pong on
      test_name = "ping-pong first load";
      start_load(32'h3000_0000, burst_len_t'(LEN_PA), 10'd6, 10'd8, 10'd8, 10'd0, 10'd1,
                 1'b1, 1'b0);
      lookup_sweep("ping-pong after first load");
      test_name = "ping-pong second load";
      start_load(32'h4000_8000, burst_len_t'(LEN_PB), 10'd16, 10'd3, 10'd2, 10'd1, 10'd2,
                 1'b1, 1'b0);
      lookup_sweep("ping-pong after second load");
      test_name = "ping-pong third load";
      start_load(32'h5000_0100, burst_len_t'(LEN_PC), 10'd4, 10'd4, 10'd4, 10'd0, 10'd2,
                 1'b1, 1'b0);
      lookup_sweep("ping-pong after third load");

      $display("No errors");
      $finish;
   end

endmodule

//--- all.f
+incdir+logic
logic/lut_bus_pkg.sv
logic/lut_cfg_pkg.sv
logic/lut_load_ctrl.sv
logic/lut_addr_gen.sv
logic/lut_join.sv
logic/lut_dual_ram.sv
logic/lut_lane_read.sv
logic/lut_read_top.sv
test/lut_tb.sv

//--- run.sh
#!/bin/sh
# Builds the lut_tb simulation with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -Wno-fatal \
   --top-module lut_tb \
   -f all.f \
   -o lut_sim

./obj_dir/lut_sim
